// ==== source/eth_rx_settings.svh ====
`ifndef ETH_RX_SETTINGS_SVH
`define ETH_RX_SETTINGS_SVH

//////////////////////////////////////////////////
// Ethernet receive framing constants
//////////////////////////////////////////////////

// Preamble octet, repeated before the delimiter
`define ETH_PREAMBLE_BYTE 8'h55

// Start-of-frame delimiter that closes the preamble
`define ETH_SFD_BYTE 8'hd5

// Length of the frame check sequence in bytes
// Also the depth of the hold-back window in the packer
`define ETH_FCS_BYTES 4

`endif

// ==== source/eth_rx_pkg.sv ====
`default_nettype none

package eth_rx_pkg;

	// One GMII receive beat as sampled at the pins
	typedef struct packed {
		logic		dv;
		logic		er;
		logic [7:0]	rxd;
	} gmii_rx_t;

	// Byte stream out of the framer
	// sof and eof are single-cycle pulses that never carry data
	typedef struct packed {
		logic		valid;
		logic [7:0]	data;
		logic		sof;
		logic		eof;
		logic		err;
	} rx_byte_t;

	// Upper-layer word, first byte on the wire in the top byte
	typedef struct packed {
		logic		valid;
		logic [2:0]	bytes_valid;
		logic [31:0]	data;
	} rx_word_t;

	// End-of-frame record handed from the packer to the checker
	typedef struct packed {
		logic		eof;
		logic		err;
		logic [31:0]	part_data;
		logic [1:0]	part_count;
		logic [31:0]	crc;
		logic [31:0]	fcs;
		logic		long_enough;
	} rx_tail_t;

endpackage

`default_nettype wire

// ==== source/crc32_ethernet.sv ====
`timescale 1ns/1ps
`default_nettype none

module crc32_ethernet (
	input wire		gmii_rx_clk,
	input wire		rst,
	input wire		crc_reset,
	input wire		update,
	input wire [7:0]	din,
	output logic [31:0]	crc
);

	// 04c11db7 in its reflected, LSB-first form
	localparam logic [31:0] poly_reflected = 32'hedb88320;

	logic [31:0] crc_state;

	// Eight serial steps, bit 0 of the byte goes first as on the wire
	function automatic logic [31:0] crc_step(input logic [31:0] c, input logic [7:0] d);
		logic [31:0] r;
		r = c;
		for (int i = 0; i < 8; i++) begin
			if (r[0] ^ d[i])
				r = (r >> 1) ^ poly_reflected;
			else
				r = r >> 1;
		end
		return r;
	endfunction

	// Seed with all ones at the start of every frame
	always_ff @(posedge gmii_rx_clk) begin
		if (rst || crc_reset)
			crc_state <= '1;
		else if (update)
			crc_state <= crc_step(crc_state, din);
	end

	// Complemented, low byte first, so it lines up with the received FCS word
	assign crc = ~{crc_state[7:0], crc_state[15:8], crc_state[23:16], crc_state[31:24]};

endmodule

`default_nettype wire

// ==== source/gmii_rx_framer.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "eth_rx_settings.svh"

module gmii_rx_framer (
	input wire			gmii_rx_clk,
	input wire			rst,
	input wire eth_rx_pkg::gmii_rx_t	gmii,
	input wire			link_up,
	output eth_rx_pkg::rx_byte_t	rx_byte
);
	import eth_rx_pkg::*;

	typedef enum logic [1:0] {
		rx_idle,
		rx_preamble,
		rx_data,
		rx_drop
	} rx_state_t;

	rx_state_t	state;
	gmii_rx_t	gmii_q;
	logic		err_seen;
	logic		sfd_hit;

	//////////////////////////////////////////////////
	// Input register

	// One flop stage on the GMII bus, only dv matters after reset
	always_ff @(posedge gmii_rx_clk) begin
		gmii_q <= gmii;
		if (rst)
			gmii_q.dv <= 1'b0;
	end

	// Clean delimiter beat with the link still up
	assign sfd_hit = gmii_q.dv && !gmii_q.er && link_up && (gmii_q.rxd == `ETH_SFD_BYTE);

	//////////////////////////////////////////////////
	// Receive state machine

	always_ff @(posedge gmii_rx_clk) begin
		if (rst) begin
			state		<= rx_idle;
			err_seen	<= 1'b0;
		end else begin
			case (state)
				// Only a clean 55 may open a frame
				rx_idle: begin
					if (gmii_q.dv) begin
						if (link_up && !gmii_q.er && (gmii_q.rxd == `ETH_PREAMBLE_BYTE))
							state <= rx_preamble;
						else
							state <= rx_drop;
					end
				end
				// Runts ending here vanish without any upper-layer activity
				rx_preamble: begin
					if (!gmii_q.dv)
						state <= rx_idle;
					else if (sfd_hit) begin
						state		<= rx_data;
						err_seen	<= 1'b0;
					end else if (gmii_q.er || !link_up || (gmii_q.rxd != `ETH_PREAMBLE_BYTE))
						state <= rx_drop;
				end
				rx_data: begin
					// Link loss cuts the frame short on this very beat
					if (!link_up)
						state <= gmii_q.dv ? rx_drop : rx_idle;
					else if (!gmii_q.dv)
						state <= rx_idle;
					else if (gmii_q.er)
						err_seen <= 1'b1;
				end
				// Skip the rest of a bad burst
				rx_drop: begin
					if (!gmii_q.dv)
						state <= rx_idle;
				end
				default: state <= rx_idle;
			endcase
		end
	end

	//////////////////////////////////////////////////
	// Byte strobes, decoded from state and the registered beat

	always_comb begin
		rx_byte = '0;
		rx_byte.data = gmii_q.rxd;
		case (state)
			rx_preamble: rx_byte.sof = sfd_hit;
			rx_data: begin
				rx_byte.valid	= gmii_q.dv && link_up;
				rx_byte.eof	= !gmii_q.dv || !link_up;
				// Error flag rides on the end pulse only
				rx_byte.err	= rx_byte.eof && (err_seen || !link_up);
			end
			default: ;
		endcase
	end

endmodule

`default_nettype wire

// ==== source/rx_word_packer.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "eth_rx_settings.svh"

module rx_word_packer (
	input wire			gmii_rx_clk,
	input wire			rst,
	input wire eth_rx_pkg::rx_byte_t	rx_byte,
	output eth_rx_pkg::rx_word_t	word,
	output eth_rx_pkg::rx_tail_t	tail
);
	import eth_rx_pkg::*;

	logic [31:0]		crc_now;
	logic [31:0]		fcs_window;
	logic [3:0][31:0]	crc_hist;
	logic [31:0]		pack_data;
	logic [31:0]		pack_next;
	logic [1:0]		pack_pos;
	logic [31:0]		hold_data;
	logic			hold_valid;
	logic [2:0]		byte_cnt;
	logic			release_byte;

	crc32_ethernet u_crc (
		.gmii_rx_clk	(gmii_rx_clk),
		.rst		(rst),
		.crc_reset	(rx_byte.sof),
		.update		(rx_byte.valid),
		.din		(rx_byte.data),
		.crc		(crc_now)
	);

	// Oldest window byte leaves only once the window is full
	assign release_byte	= rx_byte.valid && (byte_cnt >= 3'(`ETH_FCS_BYTES));
	assign pack_next	= {pack_data[23:0], fcs_window[31:24]};

	//////////////////////////////////////////////////
	// Word sequencing and tail record

	always_ff @(posedge gmii_rx_clk) begin
		if (rst) begin
			word.valid	<= 1'b0;
			tail.eof	<= 1'b0;
			hold_valid	<= 1'b0;
			pack_pos	<= '0;
			byte_cnt	<= '0;
		end else begin
			word.valid	<= 1'b0;
			tail.eof	<= 1'b0;
			// Start marker travels as a word with no bytes
			if (rx_byte.sof) begin
				word		<= '{valid: 1'b1, bytes_valid: 3'd0, data: 32'd0};
				hold_valid	<= 1'b0;
				pack_pos	<= '0;
				byte_cnt	<= '0;
			end
			if (rx_byte.valid) begin
				// Saturating, only small counts matter
				if (byte_cnt != 3'd7)
					byte_cnt <= byte_cnt + 3'd1;
				if (release_byte) begin
					pack_pos <= pack_pos + 2'd1;
					// Word complete, so the previous one is safe to send
					if (pack_pos == 2'd3) begin
						hold_valid <= 1'b1;
						if (hold_valid)
							word <= '{valid: 1'b1, bytes_valid: 3'd4, data: hold_data};
					end
				end
			end
			if (rx_byte.eof) begin
				// Last full word goes out alongside the tail
				if (hold_valid)
					word <= '{valid: 1'b1, bytes_valid: 3'd4, data: hold_data};
				hold_valid		<= 1'b0;
				tail.eof		<= 1'b1;
				tail.err		<= rx_byte.err;
				tail.part_data		<= pack_data;
				tail.part_count		<= pack_pos;
				tail.crc		<= crc_hist[3];
				tail.fcs		<= fcs_window;
				tail.long_enough	<= byte_cnt > 3'(`ETH_FCS_BYTES);
			end
		end
	end

	//////////////////////////////////////////////////
	// Payload shifters

	always_ff @(posedge gmii_rx_clk) begin
		if (rx_byte.valid) begin
			fcs_window	<= {fcs_window[23:0], rx_byte.data};
			// CRC before each byte, slot 3 ends up four bytes behind
			crc_hist	<= {crc_hist[2:0], crc_now};
			if (release_byte)
				pack_data <= pack_next;
			if (release_byte && (pack_pos == 2'd3))
				hold_data <= pack_next;
		end
	end

endmodule

`default_nettype wire

// ==== source/rx_fcs_check.sv ====
`timescale 1ns/1ps
`default_nettype none

module rx_fcs_check (
	input wire			gmii_rx_clk,
	input wire			rst,
	input wire eth_rx_pkg::rx_word_t	word,
	input wire eth_rx_pkg::rx_tail_t	tail,
	output logic			rx_frame_start,
	output logic			rx_frame_data_valid,
	output logic [2:0]		rx_frame_bytes_valid,
	output logic [31:0]		rx_frame_data,
	output logic			rx_frame_commit,
	output logic			rx_frame_drop
);
	import eth_rx_pkg::*;

	typedef enum logic [1:0] {
		chk_idle,
		chk_tail_word,
		chk_verdict
	} chk_state_t;

	chk_state_t	state;
	rx_tail_t	tail_q;
	logic [31:0]	part_aligned;
	logic		fcs_ok;

	// Tail record is held until the verdict
	always_ff @(posedge gmii_rx_clk) begin
		if (tail.eof)
			tail_q <= tail;
	end

	// Partial word moves to the top bytes, zero filled below
	always_comb begin
		case (tail_q.part_count)
			2'd1:		part_aligned = {tail_q.part_data[7:0], 24'h0};
			2'd2:		part_aligned = {tail_q.part_data[15:0], 16'h0};
			default:	part_aligned = {tail_q.part_data[23:0], 8'h0};
		endcase
	end

	// Runt, errored or bad CRC frames all drop
	assign fcs_ok = tail_q.long_enough && !tail_q.err && (tail_q.crc == tail_q.fcs);

	//////////////////////////////////////////////////
	// Upper-layer output registers

	always_ff @(posedge gmii_rx_clk) begin
		if (rst) begin
			state			<= chk_idle;
			rx_frame_start		<= 1'b0;
			rx_frame_data_valid	<= 1'b0;
			rx_frame_bytes_valid	<= '0;
			rx_frame_commit		<= 1'b0;
			rx_frame_drop		<= 1'b0;
		end else begin
			rx_frame_start		<= 1'b0;
			rx_frame_data_valid	<= 1'b0;
			rx_frame_commit		<= 1'b0;
			rx_frame_drop		<= 1'b0;
			// Empty word is the start marker
			if (word.valid) begin
				if (word.bytes_valid == 3'd0)
					rx_frame_start <= 1'b1;
				else begin
					rx_frame_data_valid	<= 1'b1;
					rx_frame_bytes_valid	<= word.bytes_valid;
					rx_frame_data		<= word.data;
				end
			end
			case (state)
				chk_idle: begin
					if (tail.eof)
						state <= chk_tail_word;
				end
				// Slot after the last full word
				chk_tail_word: begin
					if (tail_q.part_count != 2'd0) begin
						rx_frame_data_valid	<= 1'b1;
						rx_frame_bytes_valid	<= {1'b0, tail_q.part_count};
						rx_frame_data		<= part_aligned;
					end
					state <= chk_verdict;
				end
				chk_verdict: begin
					rx_frame_commit	<= fcs_ok;
					rx_frame_drop	<= !fcs_ok;
					state		<= chk_idle;
				end
				default: state <= chk_idle;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== source/eth_rx_mac.sv ====
`timescale 1ns/1ps
`default_nettype none

module eth_rx_mac (
	input wire		gmii_rx_clk,
	input wire		rst,
	input wire		gmii_rx_dv,
	input wire		gmii_rx_er,
	input wire [7:0]	gmii_rxd,
	input wire		link_up,
	output wire		rx_frame_start,
	output wire		rx_frame_data_valid,
	output wire [2:0]	rx_frame_bytes_valid,
	output wire [31:0]	rx_frame_data,
	output wire		rx_frame_commit,
	output wire		rx_frame_drop
);
	import eth_rx_pkg::*;

	gmii_rx_t	gmii_bus;
	rx_byte_t	rx_byte;
	rx_word_t	word;
	rx_tail_t	tail;

	assign gmii_bus = '{dv: gmii_rx_dv, er: gmii_rx_er, rxd: gmii_rxd};

	//////////////////////////////////////////////////
	// Framer, packer, checker in a straight line

	gmii_rx_framer u_framer (
		.gmii_rx_clk	(gmii_rx_clk),
		.rst		(rst),
		.gmii		(gmii_bus),
		.link_up	(link_up),
		.rx_byte	(rx_byte)
	);

	rx_word_packer u_packer (
		.gmii_rx_clk	(gmii_rx_clk),
		.rst		(rst),
		.rx_byte	(rx_byte),
		.word		(word),
		.tail		(tail)
	);

	rx_fcs_check u_check (
		.gmii_rx_clk		(gmii_rx_clk),
		.rst			(rst),
		.word			(word),
		.tail			(tail),
		.rx_frame_start		(rx_frame_start),
		.rx_frame_data_valid	(rx_frame_data_valid),
		.rx_frame_bytes_valid	(rx_frame_bytes_valid),
		.rx_frame_data		(rx_frame_data),
		.rx_frame_commit	(rx_frame_commit),
		.rx_frame_drop		(rx_frame_drop)
	);

endmodule

`default_nettype wire

// ==== verif/eth_rx_monitor.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "eth_rx_settings.svh"

module eth_rx_monitor (
	input wire			gmii_rx_clk,
	input wire			rst,
	input wire			rx_frame_start,
	input wire			rx_frame_data_valid,
	input wire [2:0]		rx_frame_bytes_valid,
	input wire [31:0]		rx_frame_data,
	input wire			rx_frame_commit,
	input wire			rx_frame_drop,
	input wire			exp_strobe,
	input wire			exp_visible,
	input wire			exp_err,
	input wire [6:0]		exp_count,
	input wire [0:95][7:0]		exp_bytes,
	input wire			run_done,
	output logic [15:0]		mismatch_errors,
	output logic [15:0]		protocol_errors
);

	// Bytes the framer should accept after the delimiter, FCS included
	logic [0:95][7:0]	ref_bytes;
	int			ref_count;
	logic			ref_err;
	// Expected frame that should show up on the upper-layer bus
	logic			pend_valid;
	logic			pend_started;
	logic			pend_done;
	// DUT side, between start and verdict
	logic			in_frame;
	logic			reset_seen;
	logic			end_checked;
	int			word_idx;
	logic [2:0]		bv_expected;
	logic			commit_expected;

	initial begin
		mismatch_errors	= '0;
		protocol_errors	= '0;
		pend_valid	= 1'b0;
		pend_started	= 1'b0;
		pend_done	= 1'b0;
		in_frame	= 1'b0;
		reset_seen	= 1'b0;
		end_checked	= 1'b0;
		word_idx	= 0;
	end

	//////////////////////////////////////////////////
	// Reference model

	// Payload left for the upper layer once the FCS is held back
	function automatic int payload_len();
		return (ref_count > `ETH_FCS_BYTES) ? ref_count - `ETH_FCS_BYTES : 0;
	endfunction

	// Serial CRC-32 over the payload, then compared with the FCS as it came in
	function automatic logic fcs_matches();
		logic [31:0]	c;
		int		p;
		p = payload_len();
		c = 32'hffffffff;
		for (int i = 0; i < p; i++)
			for (int b = 0; b < 8; b++)
				c = (c[0] ^ ref_bytes[i][b]) ? ((c >> 1) ^ 32'hedb88320) : (c >> 1);
		c = ~c;
		return {ref_bytes[p], ref_bytes[p + 1], ref_bytes[p + 2], ref_bytes[p + 3]} ==
			{c[7:0], c[15:8], c[23:16], c[31:24]};
	endfunction

	// First byte in the top lane, zero fill past the payload
	function automatic logic [31:0] expected_data(input int k);
		logic [31:0] w;
		w = '0;
		for (int b = 0; b < 4; b++)
			if (4 * k + b < payload_len())
				w[31 - 8 * b -: 8] = ref_bytes[4 * k + b];
		return w;
	endfunction

	task automatic report_mismatch(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		$display("Mismatch at %0t: %s expected %0h actual %0h", $time, name, expected, actual);
		mismatch_errors = mismatch_errors + 16'd1;
	endtask

	task automatic report_failure(input string what);
		$display("Error at %0t: %s", $time, what);
		protocol_errors = protocol_errors + 16'd1;
	endtask

	//////////////////////////////////////////////////
	// Checker

	always @(posedge gmii_rx_clk) begin
		if (rst) begin
			// First reset edge still shows power-up values
			if (reset_seen && ({rx_frame_start, rx_frame_data_valid, rx_frame_commit,
					rx_frame_drop} !== 4'b0))
				report_failure("control output high while reset is asserted");
			reset_seen = 1'b1;
		end else begin
			// New expectation, the previous one must be finished by now
			if (exp_strobe) begin
				if (pend_valid && !pend_done)
					report_failure("missing frame, expected output never completed");
				pend_valid	= exp_visible;
				pend_started	= 1'b0;
				pend_done	= 1'b0;
				ref_bytes	= exp_bytes;
				ref_count	= int'(exp_count);
				ref_err		= exp_err;
			end
			if (rx_frame_start) begin
				if (in_frame)
					report_failure("start while the previous frame has no verdict");
				else if (!pend_valid || pend_started)
					report_failure("start with no expected frame");
				in_frame	= 1'b1;
				pend_started	= 1'b1;
				word_idx	= 0;
			end
			if (rx_frame_data_valid) begin
				if (!in_frame)
					report_failure("data word outside a frame");
				else if (pend_valid) begin
					if (word_idx >= (payload_len() + 3) / 4)
						report_failure("data word beyond the expected payload");
					else begin
						bv_expected = 3'((payload_len() - 4 * word_idx >= 4) ?
							4 : payload_len() - 4 * word_idx);
						if (rx_frame_bytes_valid !== bv_expected)
							report_mismatch("rx_frame_bytes_valid", 32'(bv_expected),
								32'(rx_frame_bytes_valid));
						if (rx_frame_data !== expected_data(word_idx))
							report_mismatch("rx_frame_data", expected_data(word_idx),
								rx_frame_data);
					end
				end
				word_idx++;
			end
			// Verdict closes the frame
			if (rx_frame_commit || rx_frame_drop) begin
				if (rx_frame_commit && rx_frame_drop)
					report_failure("commit and drop in the same cycle");
				if (!in_frame)
					report_failure("verdict with no start");
				else if (pend_valid) begin
					if (word_idx != (payload_len() + 3) / 4)
						report_failure($sformatf("frame ended after %0d words, expected %0d",
							word_idx, (payload_len() + 3) / 4));
					commit_expected = (ref_count > `ETH_FCS_BYTES) && !ref_err && fcs_matches();
					if (rx_frame_commit !== commit_expected)
						report_mismatch("rx_frame_commit", 32'(commit_expected),
							32'(rx_frame_commit));
					pend_done = 1'b1;
				end
				in_frame = 1'b0;
			end
			if (run_done && !end_checked) begin
				if (in_frame)
					report_failure("start with no verdict at the end of the run");
				if (pend_valid && !pend_done)
					report_failure("missing frame at the end of the run");
				end_checked = 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

// ==== verif/tb_eth_rx_mac.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "eth_rx_settings.svh"

module tb_eth_rx_mac;

	localparam int frame_total = 200;
	localparam int cycle_limit = frame_total * 100 + 1000;

	logic			gmii_rx_clk;
	logic			rst;
	logic			gmii_rx_dv;
	logic			gmii_rx_er;
	logic [7:0]		gmii_rxd;
	logic			link_up;
	wire			rx_frame_start;
	wire			rx_frame_data_valid;
	wire [2:0]		rx_frame_bytes_valid;
	wire [31:0]		rx_frame_data;
	wire			rx_frame_commit;
	wire			rx_frame_drop;
	// Expectation record handed to the monitor
	logic			exp_strobe;
	logic			exp_visible;
	logic			exp_err;
	logic [6:0]		exp_count;
	logic [0:95][7:0]	exp_bytes;
	logic			run_done;
	wire [15:0]		mismatch_errors;
	wire [15:0]		protocol_errors;
	int unsigned		seed;
	int unsigned		first_draw;
	int			cycle_count = 0;

	initial gmii_rx_clk = 1'b0;
	always #10 gmii_rx_clk = ~gmii_rx_clk;

	eth_rx_mac DUT (
		.gmii_rx_clk		(gmii_rx_clk),
		.rst			(rst),
		.gmii_rx_dv		(gmii_rx_dv),
		.gmii_rx_er		(gmii_rx_er),
		.gmii_rxd		(gmii_rxd),
		.link_up		(link_up),
		.rx_frame_start		(rx_frame_start),
		.rx_frame_data_valid	(rx_frame_data_valid),
		.rx_frame_bytes_valid	(rx_frame_bytes_valid),
		.rx_frame_data		(rx_frame_data),
		.rx_frame_commit	(rx_frame_commit),
		.rx_frame_drop		(rx_frame_drop)
	);

	eth_rx_monitor u_monitor (
		.gmii_rx_clk		(gmii_rx_clk),
		.rst			(rst),
		.rx_frame_start		(rx_frame_start),
		.rx_frame_data_valid	(rx_frame_data_valid),
		.rx_frame_bytes_valid	(rx_frame_bytes_valid),
		.rx_frame_data		(rx_frame_data),
		.rx_frame_commit	(rx_frame_commit),
		.rx_frame_drop		(rx_frame_drop),
		.exp_strobe		(exp_strobe),
		.exp_visible		(exp_visible),
		.exp_err		(exp_err),
		.exp_count		(exp_count),
		.exp_bytes		(exp_bytes),
		.run_done		(run_done),
		.mismatch_errors	(mismatch_errors),
		.protocol_errors	(protocol_errors)
	);

	// One byte into the reflected CRC register, XOR first form
	function automatic logic [31:0] crc_add_byte(input logic [31:0] c, input logic [7:0] d);
		logic [31:0] r;
		r = c ^ {24'h0, d};
		repeat (8)
			r = r[0] ? ((r >> 1) ^ 32'hedb88320) : (r >> 1);
		return r;
	endfunction

	// Neither a preamble byte nor a delimiter
	function automatic logic [7:0] junk_byte();
		logic [7:0] b;
		b = 8'($urandom);
		while (b == `ETH_PREAMBLE_BYTE || b == `ETH_SFD_BYTE)
			b = 8'($urandom);
		return b;
	endfunction

	task automatic drive_beat(input logic dv, input logic er, input logic [7:0] d,
			input logic link);
		@(negedge gmii_rx_clk);
		gmii_rx_dv	= dv;
		gmii_rx_er	= er;
		gmii_rxd	= d;
		link_up		= link;
		exp_strobe	= 1'b0;
	endtask

	task automatic print_counts();
		$display("Errors: %0d mismatches, %0d protocol errors", mismatch_errors,
			protocol_errors);
	endtask

	//////////////////////////////////////////////////
	// Frame generator
	// Kinds 0-2 good, 3 bad FCS, 4 bad preamble, 5 er in data, 6 runt, 7 link loss

	task automatic send_frame();
		int		kind;
		int		sub;
		int		pre_len;
		int		bad_pos;
		int		total;
		int		er_pos;
		int		cut;
		int		flip;
		int		gap;
		logic [31:0]	crc;
		kind	= int'($urandom % 8);
		sub	= int'($urandom % 4);
		pre_len	= 1 + int'($urandom % 7);
		bad_pos	= (sub == 0) ? 0 : int'($urandom % pre_len);
		total	= `ETH_FCS_BYTES + int'($urandom % 81);
		er_pos	= int'($urandom % total);
		cut	= 1 + int'($urandom % (total - 1));
		gap	= 12 + int'($urandom % 8);
		// Payload, then the complemented CRC low byte first
		crc = '1;
		for (int i = 0; i < total - `ETH_FCS_BYTES; i++) begin
			exp_bytes[i] = 8'($urandom);
			crc = crc_add_byte(crc, exp_bytes[i]);
		end
		crc = ~crc;
		for (int i = 0; i < `ETH_FCS_BYTES; i++)
			exp_bytes[total - `ETH_FCS_BYTES + i] = crc[8 * i +: 8];
		if (kind == 3) begin
			flip = int'($urandom % 32);
			exp_bytes[total - 4 + flip / 8][flip % 8] = ~exp_bytes[total - 4 + flip / 8][flip % 8];
		end
		// Runt of zero to four bytes after the delimiter
		if (kind == 6) begin
			total = int'($urandom % 5);
			for (int i = 0; i < total; i++)
				exp_bytes[i] = 8'($urandom);
		end
		// Link loss stops the byte count one beat early
		@(negedge gmii_rx_clk);
		exp_visible	= (kind != 4);
		exp_err		= (kind == 5) || (kind == 7);
		exp_count	= 7'((kind == 7) ? cut - 1 : total);
		exp_strobe	= 1'b1;
		for (int i = 0; i < pre_len; i++)
			drive_beat(1'b1, (kind == 4) && (sub == 1) && (i == 0),
				((kind == 4) && (sub % 2 == 0) && (i == bad_pos)) ?
				junk_byte() : `ETH_PREAMBLE_BYTE, 1'b1);
		// Subtype 3 stops inside the preamble
		if (!((kind == 4) && (sub == 3))) begin
			drive_beat(1'b1, 1'b0, `ETH_SFD_BYTE, 1'b1);
			for (int i = 0; i < total; i++)
				drive_beat(1'b1, (kind == 5) && (i == er_pos), exp_bytes[i],
					!((kind == 7) && (i >= cut)));
		end
		// Link comes back a few idle cycles into the gap
		for (int g = 0; g < gap; g++)
			drive_beat(1'b0, 1'b0, 8'h00, !((kind == 7) && (g < 4)));
	endtask

	//////////////////////////////////////////////////
	// Main sequence

	initial begin
		seed		= 32'hc13f6f32;
		first_draw	= $urandom(seed);
		rst		= 1'b1;
		gmii_rx_dv	= 1'b0;
		gmii_rx_er	= 1'b0;
		gmii_rxd	= 8'h00;
		link_up		= 1'b1;
		exp_strobe	= 1'b0;
		exp_visible	= 1'b0;
		exp_err		= 1'b0;
		exp_count	= '0;
		exp_bytes	= '0;
		run_done	= 1'b0;
		repeat (16) @(posedge gmii_rx_clk);
		@(negedge gmii_rx_clk);
		rst = 1'b0;
		repeat (4) drive_beat(1'b0, 1'b0, 8'h00, 1'b1);
		for (int f = 0; f < frame_total; f++)
			send_frame();
		@(negedge gmii_rx_clk);
		run_done = 1'b1;
		repeat (2) @(posedge gmii_rx_clk);
		print_counts();
		if ((mismatch_errors == 0) && (protocol_errors == 0))
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

	// Run limit from the frame count
	always @(posedge gmii_rx_clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= cycle_limit) begin
			$display("Run stopped after %0d cycles, the frames did not finish in time",
				cycle_count);
			print_counts();
			$display("TEST FAIL");
			$finish;
		end
	end

endmodule

`default_nettype wire

// ==== compile.f ====
+incdir+source
source/eth_rx_pkg.sv
source/crc32_ethernet.sv
source/gmii_rx_framer.sv
source/rx_word_packer.sv
source/rx_fcs_check.sv
source/eth_rx_mac.sv
verif/eth_rx_monitor.sv
verif/tb_eth_rx_mac.sv
